//--- logic/dma_pkg.sv
package dma_pkg;

  // bus and counter widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int LEN_W  = 32;
  localparam int CNT_W  = 16;
  localparam int TAG_W  = 8;
  localparam int HDR_W  = 64;
  localparam int USER_W = HDR_W + 1; // header plus first-partition flag

  // bundle table geometry
  localparam int N_BUNDLES = 8;
  localparam int REC_W     = 256;
  localparam int RAM_WORDS = N_BUNDLES * REC_W / DATA_W; // 64 words
  localparam int REC_AW    = $clog2(N_BUNDLES);
  localparam int RAM_WAW   = $clog2(RAM_WORDS);

  // register map, everything from RAM_BASE up goes to the table
  localparam int R_START        = 0;
  localparam int R_DONE_READ0   = 1;
  localparam int R_DONE_READ1   = 2;
  localparam int R_DONE_WRITE0  = 3;
  localparam int R_DONE_WRITE1  = 4;
  localparam int R_OCM_BASE0    = 5;
  localparam int R_OCM_BASE1    = 6;
  localparam int R_WEIGHTS_BASE = 7;
  localparam int R_BUNDLE_DONE  = 8;
  localparam int R_N_BUNDLES    = 9;
  localparam int R_W_DONE       = 10;
  localparam int R_X_DONE       = 11;
  localparam int R_O_DONE       = 12;
  localparam int N_REGS         = 13;
  localparam int RAM_BASE       = 16;

  // bit offsets inside one bundle record, msb field first
  localparam int HDR_OFS      = 192;
  localparam int MAX_T_OFS    = 176;
  localparam int MAX_P_OFS    = 160;
  localparam int W_BPT_OFS    = 128;
  localparam int W_BPT_P0_OFS = 96;
  localparam int X_BPT_OFS    = 64;
  localparam int X_BPT_P0_OFS = 32;
  localparam int X_BASE_OFS   = 0;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [LEN_W-1:0]  len_t;
  typedef logic [CNT_W-1:0]  cnt_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [USER_W-1:0] user_t;
  typedef logic [REC_W-1:0]  rec_t;
  typedef logic [REC_AW-1:0] rec_idx_t;
  typedef logic [HDR_W-1:0]  header_t;

endpackage

//--- logic/bundle_ram.sv
`timescale 1ns/1ps

// bundle parameter table
// narrow write side for the register port, one full record per read
module bundle_ram import dma_pkg::*; (
  input  logic               clk,

  input  logic               i_we,
  input  logic [RAM_WAW-1:0] i_waddr,
  input  data_t              i_wdata,

  input  logic               i_re,
  input  rec_idx_t           i_raddr,
  output rec_t               o_rdata
);

  data_t mem [RAM_WORDS];

  // processor side, one word per write
  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // word k of record r sits at r*8 + k, word 7 lands in the top bits
  always_ff @(posedge clk) begin
    if (i_re) begin
      for (int k = 0; k < REC_W / DATA_W; k++) begin
        o_rdata[k*DATA_W +: DATA_W] <= mem[{i_raddr, (RAM_WAW-REC_AW)'(k)}];
      end
    end
  end

endmodule

//--- logic/loop_counter.sv
`timescale 1ns/1ps

// loadable down-counter for the transfer, partition and bundle loops
// counts from the loaded value to zero and starts over from it
module loop_counter import dma_pkg::*; (
  input  logic clk,
  input  logic rstn,
  input  logic i_load,
  input  cnt_t i_max,   // number of counts minus one
  input  logic i_en,
  output cnt_t o_count,
  output logic o_first,
  output logic o_last,
  output logic o_wrap
);

  cnt_t count;
  cnt_t max_q; // kept for the reload on wrap

  always_ff @(posedge clk) begin
    if (!rstn) begin
      count <= '0;
      max_q <= '0;
    end else if (i_load) begin
      count <= i_max;
      max_q <= i_max;
    end else if (i_en) begin
      if (count == '0) count <= max_q;
      else             count <= count - cnt_t'(1);
    end
  end

  assign o_count = count;
  assign o_first = (count == max_q);
  assign o_last  = (count == '0);
  assign o_wrap  = o_last && i_en; // last count being consumed

endmodule

//--- logic/stream_desc_gen.sv
`timescale 1ns/1ps

// read descriptor walker, bundles -> partitions -> transfers
// PIXELS = 0 walks weights, PIXELS = 1 walks pixels
module stream_desc_gen import dma_pkg::*; #(
  parameter bit PIXELS = 0
) (
  input  logic     clk,
  input  logic     rstn,

  input  logic     i_start,
  input  data_t    i_n_bundles,
  input  addr_t    i_weights_base,
  input  logic     i_bundle_done,
  output logic     o_bundle_taken,

  output logic     o_rd_req,
  output rec_idx_t o_rd_idx,
  input  logic     i_rd_valid,
  input  rec_t     i_rec,

  output addr_t    o_addr,
  output len_t     o_len,
  output user_t    o_user,
  output logic     o_valid,
  input  logic     i_ready,

  output logic     o_idle
);

  typedef enum logic [1:0] {S_IDLE, S_WAIT_RAM, S_WAIT_WRITE, S_EXEC} state_t;

  state_t  state, state_next;
  header_t header_q;
  len_t    bpt_q, bpt_p0_q;
  cnt_t    rec_max_t, rec_max_p, n_last, count_b;
  logic    fire, t_wrap, p_wrap, b_wrap, first_p;

  assign rec_max_t = i_rec[MAX_T_OFS +: CNT_W] - cnt_t'(1);
  assign rec_max_p = i_rec[MAX_P_OFS +: CNT_W] - cnt_t'(1);
  assign n_last    = cnt_t'(i_n_bundles - data_t'(1));

  always_comb begin
    state_next = state;
    unique case (state)
      S_IDLE:       if (i_start) state_next = S_WAIT_RAM;
      S_WAIT_RAM:   if (i_rd_valid) state_next = PIXELS ? S_WAIT_WRITE : S_EXEC;
      S_WAIT_WRITE: if (i_bundle_done) state_next = S_EXEC;
      S_EXEC: begin
        if (b_wrap)      state_next = S_IDLE;     // last bundle finished
        else if (p_wrap) state_next = S_WAIT_RAM; // fetch the next record
      end
      default:      state_next = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) state <= S_IDLE;
    else       state <= state_next;
  end

  // bundle counter runs down, so record index = (n-1) - count
  assign o_rd_req       = (state == S_WAIT_RAM) && !i_rd_valid;
  assign o_rd_idx       = rec_idx_t'(n_last - count_b);
  assign o_bundle_taken = (state == S_WAIT_WRITE) && i_bundle_done;

  always_ff @(posedge clk) begin
    if (i_rd_valid) begin
      header_q <= i_rec[HDR_OFS +: HDR_W];
      bpt_q    <= PIXELS ? i_rec[X_BPT_OFS +: LEN_W] : i_rec[W_BPT_OFS +: LEN_W];
      bpt_p0_q <= PIXELS ? i_rec[X_BPT_P0_OFS +: LEN_W] : i_rec[W_BPT_P0_OFS +: LEN_W];
    end
  end

  // weights run one contiguous stream, pixels restart at x_base per bundle
  always_ff @(posedge clk) begin
    if (!PIXELS) begin
      if (i_start)   o_addr <= i_weights_base;
      else if (fire) o_addr <= o_addr + addr_t'(o_len);
    end else begin
      if (i_rd_valid)  o_addr <= i_rec[X_BASE_OFS +: ADDR_W];
      else if (t_wrap) o_addr <= o_addr + addr_t'(o_len); // step once per partition
    end
  end

  assign o_valid = (state == S_EXEC);
  assign fire    = o_valid && i_ready;
  assign o_len   = first_p ? bpt_p0_q : bpt_q;
  assign o_user  = {header_q, first_p};
  assign o_idle  = (state == S_IDLE);

  loop_counter u_cnt_t (
    .clk(clk), .rstn(rstn), .i_load(i_rd_valid), .i_max(rec_max_t), .i_en(fire),
    .o_count(), .o_first(), .o_last(), .o_wrap(t_wrap)
  );

  loop_counter u_cnt_p (
    .clk(clk), .rstn(rstn), .i_load(i_rd_valid), .i_max(rec_max_p), .i_en(t_wrap),
    .o_count(), .o_first(first_p), .o_last(), .o_wrap(p_wrap)
  );

  loop_counter u_cnt_b (
    .clk(clk), .rstn(rstn), .i_load(i_start), .i_max(n_last), .i_en(p_wrap),
    .o_count(count_b), .o_first(), .o_last(), .o_wrap(b_wrap)
  );

endmodule

//--- logic/output_desc_gen.sv
`timescale 1ns/1ps

// output write descriptors into two ping-pong ocm banks
module output_desc_gen import dma_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  logic       i_start,

  // engine output stream, monitored only
  input  logic       i_o_valid,
  input  logic       i_o_ready,
  input  logic       i_o_last,
  input  len_t       i_o_bpt,

  // dma write status
  input  logic       i_os_valid,
  input  tag_t       i_os_tag,
  input  logic [3:0] i_os_error,

  input  logic       i_done_read0,
  input  logic       i_done_read1,
  input  addr_t      i_ocm_base0,
  input  addr_t      i_ocm_base1,

  output addr_t      o_addr,
  output len_t       o_len,
  output tag_t       o_tag,
  output logic       o_valid,
  input  logic       i_ready,

  output logic       o_bank_claim,
  output logic       o_claim_idx,
  output logic       o_bank_written,
  output logic       o_written_idx,

  output logic       o_out_done
);

  logic bank_q;    // bank of the last issued descriptor
  logic got_last;  // i_o_bpt now belongs to a new packet
  logic next_free, issue, status_ok;

  assign next_free = bank_q ? i_done_read0 : i_done_read1;
  assign issue     = i_ready && i_o_valid && got_last && !o_valid && next_free;
  assign status_ok = i_os_valid && (i_os_error == '0);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      bank_q     <= 1'b1; // so the first packet goes to bank 0
      got_last   <= 1'b1;
      o_valid    <= 1'b0;
      o_out_done <= 1'b0;
    end else begin
      if (i_o_valid && i_o_ready && i_o_last) got_last <= 1'b1;
      if (issue) begin
        bank_q   <= !bank_q;
        got_last <= 1'b0;
        o_valid  <= 1'b1;
      end else if (o_valid && i_ready) begin
        o_valid <= 1'b0;
      end
      if (i_start || i_o_valid)    o_out_done <= 1'b0; // engine still has data
      else if (got_last && status_ok) o_out_done <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      o_addr <= bank_q ? i_ocm_base0 : i_ocm_base1;
      o_len  <= i_o_bpt;
    end
  end

  assign o_tag          = tag_t'(bank_q);
  assign o_bank_claim   = issue;
  assign o_claim_idx    = !bank_q;
  assign o_bank_written = status_ok;
  assign o_written_idx  = i_os_tag[0];

endmodule

//--- logic/dma_ctrl.sv
`timescale 1ns/1ps

// descriptor controller top
// register bank, bundle table and the three descriptor generators
module dma_ctrl import dma_pkg::*; (
  input  logic       clk,
  input  logic       rstn,

  input  logic       i_reg_wr_en,
  input  addr_t      i_reg_wr_addr,
  input  data_t      i_reg_wr_data,
  output logic       o_reg_wr_ack,
  input  logic       i_reg_rd_en,
  input  addr_t      i_reg_rd_addr,
  output data_t      o_reg_rd_data,
  output logic       o_reg_rd_ack,

  output addr_t      o_wd_addr,
  output len_t       o_wd_len,
  output user_t      o_wd_user,
  output logic       o_wd_valid,
  input  logic       i_wd_ready,

  output addr_t      o_xd_addr,
  output len_t       o_xd_len,
  output user_t      o_xd_user,
  output logic       o_xd_valid,
  input  logic       i_xd_ready,

  output addr_t      o_od_addr,
  output len_t       o_od_len,
  output tag_t       o_od_tag,
  output logic       o_od_valid,
  input  logic       i_od_ready,

  input  logic       i_o_valid,
  input  logic       i_o_ready,
  input  logic       i_o_last,
  input  len_t       i_o_bpt,

  input  logic       i_os_valid,
  input  tag_t       i_os_tag,
  input  logic [3:0] i_os_error
);

  data_t    cfg [N_REGS];
  logic     start, reg_we, ram_we, ram_re;
  logic     w_req, x_req, w_rd_valid, x_rd_valid, w_idle, x_idle, x_taken;
  rec_idx_t w_idx, x_idx;
  rec_t     rec;
  logic     claim, claim_idx, written, written_idx, out_done;

  assign o_reg_wr_ack  = 1'b1;
  assign o_reg_rd_ack  = 1'b1;
  assign o_reg_rd_data = (i_reg_rd_en && i_reg_rd_addr < N_REGS) ? cfg[i_reg_rd_addr[3:0]] : '0;

  assign reg_we = i_reg_wr_en && (i_reg_wr_addr < N_REGS);
  assign ram_we = i_reg_wr_en && (i_reg_wr_addr >= RAM_BASE);
  assign start  = cfg[R_START][0];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < N_REGS; i++) cfg[i] <= '0;
      cfg[R_DONE_READ0]  <= data_t'(1); // both banks free at reset
      cfg[R_DONE_READ1]  <= data_t'(1);
      cfg[R_BUNDLE_DONE] <= data_t'(1);
    end else begin
      if (start)   cfg[R_START] <= '0;       // one-cycle start pulse
      if (x_taken) cfg[R_BUNDLE_DONE] <= '0; // consumed by pixel walker
      if (claim) begin
        cfg[R_DONE_READ0 + claim_idx]  <= '0;
        cfg[R_DONE_WRITE0 + claim_idx] <= '0;
      end
      if (written) cfg[R_DONE_WRITE0 + written_idx] <= data_t'(1);
      cfg[R_W_DONE] <= data_t'(w_idle);
      cfg[R_X_DONE] <= data_t'(x_idle);
      cfg[R_O_DONE] <= data_t'(out_done);
      if (reg_we) cfg[i_reg_wr_addr[3:0]] <= i_reg_wr_data; // processor wins
    end
  end

  // table read arbitration, pixels first, valid one cycle later
  assign ram_re = x_req || w_req;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      x_rd_valid <= 1'b0;
      w_rd_valid <= 1'b0;
    end else begin
      x_rd_valid <= x_req;
      w_rd_valid <= w_req && !x_req;
    end
  end

  bundle_ram u_ram (
    .clk(clk),
    .i_we(ram_we), .i_waddr(RAM_WAW'(i_reg_wr_addr - RAM_BASE)), .i_wdata(i_reg_wr_data),
    .i_re(ram_re), .i_raddr(x_req ? x_idx : w_idx), .o_rdata(rec)
  );

  stream_desc_gen #(.PIXELS(0)) u_wgen (
    .clk(clk), .rstn(rstn),
    .i_start(start), .i_n_bundles(cfg[R_N_BUNDLES]), .i_weights_base(cfg[R_WEIGHTS_BASE]),
    .i_bundle_done(cfg[R_BUNDLE_DONE][0]), .o_bundle_taken(),
    .o_rd_req(w_req), .o_rd_idx(w_idx), .i_rd_valid(w_rd_valid), .i_rec(rec),
    .o_addr(o_wd_addr), .o_len(o_wd_len), .o_user(o_wd_user),
    .o_valid(o_wd_valid), .i_ready(i_wd_ready), .o_idle(w_idle)
  );

  stream_desc_gen #(.PIXELS(1)) u_xgen (
    .clk(clk), .rstn(rstn),
    .i_start(start), .i_n_bundles(cfg[R_N_BUNDLES]), .i_weights_base(cfg[R_WEIGHTS_BASE]),
    .i_bundle_done(cfg[R_BUNDLE_DONE][0]), .o_bundle_taken(x_taken),
    .o_rd_req(x_req), .o_rd_idx(x_idx), .i_rd_valid(x_rd_valid), .i_rec(rec),
    .o_addr(o_xd_addr), .o_len(o_xd_len), .o_user(o_xd_user),
    .o_valid(o_xd_valid), .i_ready(i_xd_ready), .o_idle(x_idle)
  );

  output_desc_gen u_ogen (
    .clk(clk), .rstn(rstn), .i_start(start),
    .i_o_valid(i_o_valid), .i_o_ready(i_o_ready), .i_o_last(i_o_last), .i_o_bpt(i_o_bpt),
    .i_os_valid(i_os_valid), .i_os_tag(i_os_tag), .i_os_error(i_os_error),
    .i_done_read0(cfg[R_DONE_READ0][0]), .i_done_read1(cfg[R_DONE_READ1][0]),
    .i_ocm_base0(cfg[R_OCM_BASE0]), .i_ocm_base1(cfg[R_OCM_BASE1]),
    .o_addr(o_od_addr), .o_len(o_od_len), .o_tag(o_od_tag),
    .o_valid(o_od_valid), .i_ready(i_od_ready),
    .o_bank_claim(claim), .o_claim_idx(claim_idx),
    .o_bank_written(written), .o_written_idx(written_idx),
    .o_out_done(out_done)
  );

endmodule

//--- sim/dma_ctrl_assertions.sv
`timescale 1ns/1ps

// handshake and bank checks bound into the descriptor controller
module dma_ctrl_assertions import dma_pkg::*; (
  input logic  clk,
  input logic  rstn,
  input addr_t o_wd_addr,
  input len_t  o_wd_len,
  input user_t o_wd_user,
  input logic  o_wd_valid,
  input logic  i_wd_ready,
  input addr_t o_xd_addr,
  input len_t  o_xd_len,
  input user_t o_xd_user,
  input logic  o_xd_valid,
  input logic  i_xd_ready,
  input addr_t o_od_addr,
  input len_t  o_od_len,
  input tag_t  o_od_tag,
  input logic  o_od_valid,
  input logic  i_od_ready,
  input data_t cfg [N_REGS]
);

  int n_fail = 0; // polled by the testbench

  // a stalled descriptor keeps every field
  a_wd_hold: assert property (@(posedge clk) disable iff (!rstn)
    o_wd_valid && !i_wd_ready |=> o_wd_valid && $stable({o_wd_addr, o_wd_len, o_wd_user}))
    else begin $error("weight descriptor changed while stalled"); n_fail++; end
  a_xd_hold: assert property (@(posedge clk) disable iff (!rstn)
    o_xd_valid && !i_xd_ready |=> o_xd_valid && $stable({o_xd_addr, o_xd_len, o_xd_user}))
    else begin $error("pixel descriptor changed while stalled"); n_fail++; end
  a_od_hold: assert property (@(posedge clk) disable iff (!rstn)
    o_od_valid && !i_od_ready |=> o_od_valid && $stable({o_od_addr, o_od_len, o_od_tag}))
    else begin $error("output descriptor changed while stalled"); n_fail++; end

  // weights form one contiguous stream
  a_wd_step: assert property (@(posedge clk) disable iff (!rstn)
    o_wd_valid && i_wd_ready |=> o_wd_addr == $past(o_wd_addr + o_wd_len))
    else begin $error("weight address did not advance by the length"); n_fail++; end

  a_od_base: assert property (@(posedge clk) disable iff (!rstn)
    o_od_valid |-> o_od_addr == (o_od_tag[0] ? cfg[R_OCM_BASE1] : cfg[R_OCM_BASE0]))
    else begin $error("output address is not the base of its bank"); n_fail++; end

  // the claimed bank must have been free in the issue cycle
  a_od_free: assert property (@(posedge clk) disable iff (!rstn)
    $rose(o_od_valid) |->
      (o_od_tag[0] ? $past(cfg[R_DONE_READ1][0]) : $past(cfg[R_DONE_READ0][0])))
    else begin $error("output descriptor issued into a busy bank"); n_fail++; end

endmodule

bind dma_ctrl dma_ctrl_assertions u_assertions (
  .clk(clk), .rstn(rstn),
  .o_wd_addr(o_wd_addr), .o_wd_len(o_wd_len), .o_wd_user(o_wd_user),
  .o_wd_valid(o_wd_valid), .i_wd_ready(i_wd_ready),
  .o_xd_addr(o_xd_addr), .o_xd_len(o_xd_len), .o_xd_user(o_xd_user),
  .o_xd_valid(o_xd_valid), .i_xd_ready(i_xd_ready),
  .o_od_addr(o_od_addr), .o_od_len(o_od_len), .o_od_tag(o_od_tag),
  .o_od_valid(o_od_valid), .i_od_ready(i_od_ready), .cfg(cfg)
);

//--- sim/dma_ctrl_tb.sv
`timescale 1ns/1ps

module dma_ctrl_tb import dma_pkg::*;;

  localparam int NB = 3;
  localparam int TIMEOUT_CYCLES = 4000; // room for 54 descriptors at half-rate ready and two packets

  typedef struct {
    addr_t addr;
    len_t  len;
    user_t user;
    int    bundle;
  } desc_t;

  logic clk, rstn;
  logic i_reg_wr_en, i_reg_rd_en, o_reg_wr_ack, o_reg_rd_ack;
  addr_t i_reg_wr_addr, i_reg_rd_addr, o_wd_addr, o_xd_addr, o_od_addr;
  data_t i_reg_wr_data, o_reg_rd_data;
  len_t o_wd_len, o_xd_len, o_od_len, i_o_bpt;
  user_t o_wd_user, o_xd_user;
  tag_t o_od_tag, i_os_tag;
  logic o_wd_valid, i_wd_ready, o_xd_valid, i_xd_ready, o_od_valid, i_od_ready;
  logic i_o_valid, i_o_ready, i_o_last, i_os_valid;
  logic [3:0] i_os_error;

  desc_t w_q[$], x_q[$];
  tag_t st_q[$];
  addr_t ocm_base[2];
  len_t pkt_bpt[2];
  int n_written = 0, od_count = 0, status_sent = 0;
  logic engine_go = 0, rd1_released = 0;

  dma_ctrl u_dma_ctrl (.*);

  initial begin
    clk = 0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("sim failed");
    $fatal(1);
  end

  task automatic mismatch(input string sig, input logic [64:0] exp, input logic [64:0] act);
    $display("Mismatch at %0t: %s expected %0h got %0h", $time, sig, exp, act);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string what);
    $display("error at %0t: %s", $time, what);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic reg_write(input int a, input data_t d);
    @(posedge clk);
    i_reg_wr_en <= 1;
    i_reg_wr_addr <= a;
    i_reg_wr_data <= d;
    @(posedge clk);
    i_reg_wr_en <= 0;
  endtask

  task automatic reg_read(input int a, output data_t d);
    @(posedge clk);
    i_reg_rd_en <= 1;
    i_reg_rd_addr <= a;
    @(posedge clk);
    d = o_reg_rd_data;
    i_reg_rd_en <= 0;
  endtask

  task automatic check_reg(input int a, input data_t exp);
    data_t d;
    reg_read(a, d);
    assert (d == exp) else mismatch($sformatf("reg[%0d]", a), exp, d);
  endtask

  task automatic check_desc(input string ch, input desc_t e, input addr_t a, input len_t l,
                            input user_t u);
    assert (e.addr == a) else mismatch({ch, "_addr"}, e.addr, a);
    assert (e.len == l) else mismatch({ch, "_len"}, e.len, l);
    assert (e.user == u) else mismatch({ch, "_user"}, e.user, u);
  endtask

  // ready sources toggle at random
  always @(posedge clk) begin
    i_wd_ready <= $urandom_range(0, 1);
    i_xd_ready <= $urandom_range(0, 1);
    i_od_ready <= $urandom_range(0, 1);
  end

  always @(posedge clk) begin
    if (u_dma_ctrl.u_assertions.n_fail != 0) abort_run("a bound assertion failed");
    assert (o_reg_wr_ack) else mismatch("o_reg_wr_ack", 1, o_reg_wr_ack);
    assert (o_reg_rd_ack) else mismatch("o_reg_rd_ack", 1, o_reg_rd_ack);
    if (rstn && o_wd_valid && i_wd_ready) begin
      assert (w_q.size() > 0) else abort_run("more weight descriptors than expected");
      check_desc("o_wd", w_q.pop_front(), o_wd_addr, o_wd_len, o_wd_user);
    end
    if (rstn && o_xd_valid && i_xd_ready) begin
      assert (x_q.size() > 0) else abort_run("more pixel descriptors than expected");
      assert (x_q[0].bundle < n_written) else abort_run("pixel descriptor before bundle_done");
      check_desc("o_xd", x_q.pop_front(), o_xd_addr, o_xd_len, o_xd_user);
    end
    if (rstn && o_od_valid && i_od_ready) begin
      assert (od_count < 2) else abort_run("more output descriptors than packets");
      assert (o_od_tag == tag_t'(od_count % 2))
        else mismatch("o_od_tag", od_count % 2, o_od_tag);
      assert (o_od_addr == ocm_base[o_od_tag[0]])
        else mismatch("o_od_addr", ocm_base[o_od_tag[0]], o_od_addr);
      assert (o_od_len == pkt_bpt[od_count])
        else mismatch("o_od_len", pkt_bpt[od_count], o_od_len);
      assert (o_od_tag == 0 || rd1_released) else abort_run("bank 1 claimed while not free");
      st_q.push_back(o_od_tag);
      od_count++;
    end
  end

  // engine holds each packet until its descriptor is taken
  initial begin
    while (!engine_go) @(posedge clk);
    for (int pkt = 0; pkt < 2; pkt++) begin
      i_o_valid <= 1;
      i_o_bpt <= pkt_bpt[pkt];
      while (od_count <= pkt) @(posedge clk);
      for (int beat = 0; beat < 4; beat++) begin
        i_o_ready <= 1;
        i_o_last <= (beat == 3);
        @(posedge clk);
      end
      i_o_valid <= 0;
      i_o_ready <= 0;
      i_o_last <= 0;
      @(posedge clk);
    end
  end

  // dma returns a good status 30 cycles after each descriptor
  initial begin
    forever begin
      while (st_q.size() == 0) @(posedge clk);
      repeat (30) @(posedge clk);
      i_os_valid <= 1;
      i_os_tag <= st_q.pop_front();
      @(posedge clk);
      i_os_valid <= 0;
      status_sent++;
    end
  end

  initial begin
    header_t hdr;
    cnt_t mt, mp;
    len_t wb, wb0, xb, xb0, len;
    addr_t xa, wa;
    rec_t rec;
    data_t d;
    void'($urandom(32'h401d7edb));
    {i_reg_wr_en, i_reg_rd_en, i_reg_wr_addr, i_reg_rd_addr, i_reg_wr_data} = '0;
    {i_wd_ready, i_xd_ready, i_od_ready, i_o_valid, i_o_ready, i_o_last, i_o_bpt} = '0;
    {i_os_valid, i_os_tag, i_os_error} = '0;
    rstn = 0;
    repeat (8) @(posedge clk);
    rstn <= 1;
    repeat (2) @(posedge clk);
    // idle walkers drive w_done and x_done high a cycle after reset
    for (int r = 0; r < N_REGS; r++)
      check_reg(r, (r inside {R_DONE_READ0, R_DONE_READ1, R_BUNDLE_DONE, R_W_DONE, R_X_DONE}));

    wa = '0;
    for (int b = 0; b < NB; b++) begin
      hdr = {$urandom, $urandom};
      mt = $urandom_range(1, 3);
      mp = $urandom_range(1, 3);
      {wb, wb0, xb, xb0} = {$urandom_range(1, 64) * 16, $urandom_range(1, 64) * 16,
                            $urandom_range(1, 64) * 16, $urandom_range(1, 64) * 16};
      xa = $urandom_range(1, 4095) * 256;
      rec = {hdr, mt, mp, wb, wb0, xb, xb0, xa};
      for (int k = 0; k < 8; k++) reg_write(RAM_BASE + b * 8 + k, rec[k*32 +: 32]);
      for (int p = 0; p < mp; p++) begin
        for (int t = 0; t < mt; t++) begin
          len = (p == 0) ? wb0 : wb;
          w_q.push_back('{wa, len, {hdr, p == 0}, b});
          wa += len;
          len = (p == 0) ? xb0 : xb;
          x_q.push_back('{xa, len, {hdr, p == 0}, b});
        end
        xa += len; // pixel address steps once per partition
      end
    end
    wa = $urandom_range(1, 4095) * 16;
    ocm_base[0] = $urandom_range(1, 255) * 4096;
    ocm_base[1] = ocm_base[0] + 32'h0010_0000;
    pkt_bpt[0] = $urandom_range(1, 64) * 16;
    pkt_bpt[1] = $urandom_range(1, 64) * 16;
    for (int i = 0; i < w_q.size(); i++) w_q[i].addr += wa; // table built from offset 0
    reg_write(R_WEIGHTS_BASE, wa);
    reg_write(R_OCM_BASE0, ocm_base[0]);
    reg_write(R_OCM_BASE1, ocm_base[1]);
    reg_write(R_N_BUNDLES, NB);
    reg_write(R_BUNDLE_DONE, 0);
    reg_write(R_DONE_READ1, 0);
    reg_write(R_DONE_WRITE0, 1);
    reg_write(R_DONE_WRITE1, 1);
    check_reg(R_WEIGHTS_BASE, wa);
    check_reg(R_OCM_BASE1, ocm_base[1]);
    check_reg(R_DONE_WRITE0, 1);

    reg_write(R_START, 1);
    for (int b = 0; b < NB; b++) begin
      do reg_read(R_BUNDLE_DONE, d); while (d != 0);
      repeat ($urandom_range(5, 20)) @(posedge clk);
      n_written = b + 1;
      reg_write(R_BUNDLE_DONE, 1);
    end
    while (w_q.size() != 0 || x_q.size() != 0) @(posedge clk);

    engine_go = 1;
    while (od_count < 1) @(posedge clk);
    check_reg(R_DONE_WRITE0, 0);
    while (status_sent < 1) @(posedge clk);
    repeat (2) @(posedge clk);
    check_reg(R_DONE_WRITE0, 1);
    rd1_released = 1;
    reg_write(R_DONE_READ1, 1);
    while (od_count < 2) @(posedge clk);
    check_reg(R_DONE_WRITE1, 0);
    while (status_sent < 2) @(posedge clk);
    repeat (2) @(posedge clk);
    check_reg(R_DONE_WRITE1, 1);
    check_reg(R_W_DONE, 1);
    check_reg(R_X_DONE, 1);
    check_reg(R_O_DONE, 1);

    repeat (4) @(posedge clk);
    if (u_dma_ctrl.u_assertions.n_fail != 0) begin
      $display("sim failed");
      $fatal(1);
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

//--- dma_ctrl.f
logic/dma_pkg.sv
logic/bundle_ram.sv
logic/loop_counter.sv
logic/stream_desc_gen.sv
logic/output_desc_gen.sv
logic/dma_ctrl.sv
sim/dma_ctrl_assertions.sv
sim/dma_ctrl_tb.sv
